/* mrd_defines.svh */
`ifndef MRD_DEFINES_SVH
`define MRD_DEFINES_SVH

// stage slots per frame
`define MRD_NUM_STAGES 6

// width of N, the twiddle denominators and N/radix
`define MRD_PTS_W 12

// reciprocal scale is 2^MRD_RECIP_W, also the quotient width
`define MRD_RECIP_W 20

// radix code and stage index width
`define MRD_RDX_W 3

`endif

/* mrd_pkg.sv */
`include "mrd_defines.svh"

package mrd_pkg;

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_FACTOR = 2'd1,
		ST_RECIP  = 2'd2,
		ST_DONE   = 2'd3
	} ctrl_state_e;

	// --------------------------------------------------
	// stage radix, code equals the radix value
	// --------------------------------------------------
	// RDX_1 marks an unused stage slot
	typedef enum logic [`MRD_RDX_W-1:0] {
		RDX_1 = 3'd1,
		RDX_2 = 3'd2,
		RDX_3 = 3'd3,
		RDX_4 = 3'd4,
		RDX_5 = 3'd5
	} radix_e;

endpackage

/* mrd_param_if.sv */
`include "mrd_defines.svh"

interface mrd_param_if;
	import mrd_pkg::*;

	// factorizer group
	// load residue and N at frame start
	logic                    fact_load;
	logic [`MRD_PTS_W-1:0]   fact_n;
	// one stage per pulse
	logic                    fact_step;
	radix_e                  fact_radix;
	// residue before the step, i.e. the stage denominator
	logic [`MRD_PTS_W-1:0]   fact_residue;
	logic [`MRD_PTS_W-1:0]   fact_n_div;

	// divider group
	logic                    div_start;
	logic [`MRD_PTS_W-1:0]   div_den;
	// quotient and remainder valid with done
	logic                    div_done;
	logic [`MRD_RECIP_W-1:0] div_quot;
	logic [`MRD_PTS_W-1:0]   div_rem;

	modport ctrl (
		output fact_load, fact_n, fact_step, div_start, div_den,
		input  fact_radix, fact_residue, fact_n_div, div_done, div_quot, div_rem
	);

	modport fact (
		input  fact_load, fact_n, fact_step,
		output fact_radix, fact_residue, fact_n_div
	);

	modport recip (
		input  div_start, div_den,
		output div_done, div_quot, div_rem
	);

endinterface

/* mrd_factorizer.sv */
`include "mrd_defines.svh"

module mrd_factorizer (
	input  logic       clk,
	input  logic       rst_n,
	mrd_param_if.fact  m
);
	import mrd_pkg::*;

	logic [`MRD_PTS_W-1:0] residue;
	logic [`MRD_PTS_W-1:0] n_reg;
	logic [`MRD_PTS_W-1:0] residue_next;

	// exact divide by a radix, constant divisors only
	function automatic logic [`MRD_PTS_W-1:0] div_by_radix(
		input logic [`MRD_PTS_W-1:0] x,
		input radix_e                r
	);
		logic [`MRD_PTS_W-1:0] q;
		case (r)
			RDX_4:   q = x >> 2;
			RDX_2:   q = x >> 1;
			RDX_5:   q = x / `MRD_PTS_W'(5);
			RDX_3:   q = x / `MRD_PTS_W'(3);
			default: q = x;
		endcase
		return q;
	endfunction

	// --------------------------------------------------
	// next radix, priority 4, 2, 5, 3
	// --------------------------------------------------
	always_comb begin
		if (residue[1:0] == 2'b00) begin
			m.fact_radix = RDX_4;
		end else if (residue[0] == 1'b0) begin
			m.fact_radix = RDX_2;
		end else if ((residue % `MRD_PTS_W'(5)) == '0) begin
			m.fact_radix = RDX_5;
		end else if ((residue % `MRD_PTS_W'(3)) == '0) begin
			m.fact_radix = RDX_3;
		end else begin
			// 1 or a prime factor above 5
			m.fact_radix = RDX_1;
		end
	end

	assign residue_next   = div_by_radix(residue, m.fact_radix);
	assign m.fact_n_div   = div_by_radix(n_reg, m.fact_radix);
	assign m.fact_residue = residue;

	// --------------------------------------------------
	// residue and frame length registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			residue <= '0;
			n_reg   <= '0;
		end else if (m.fact_load) begin
			residue <= m.fact_n;
			n_reg   <= m.fact_n;
		end else if (m.fact_step) begin
			// radix 1 leaves the residue as is
			residue <= residue_next;
		end
	end

endmodule

/* mrd_recip_div.sv */
`include "mrd_defines.svh"

module mrd_recip_div (
	input  logic        clk,
	input  logic        rst_n,
	mrd_param_if.recip  m
);
	// quotient bits of 2^20, msb resolved on the start cycle
	localparam int NUM_BITS = `MRD_RECIP_W + 1;

	logic [`MRD_PTS_W-1:0]   den_reg;
	logic [`MRD_PTS_W-1:0]   rem_reg;
	logic [`MRD_RECIP_W-1:0] quot_reg;
	logic [4:0]              bit_cnt;
	logic                    done_reg;

	logic [`MRD_PTS_W-1:0]   cur_rem;
	logic [`MRD_PTS_W-1:0]   cur_den;
	logic                    cur_bit;
	logic [`MRD_PTS_W:0]     trial;
	logic [`MRD_PTS_W:0]     diff;
	logic                    q_bit;
	logic [`MRD_PTS_W-1:0]   rem_next;

	// --------------------------------------------------
	// one restoring step
	// --------------------------------------------------
	always_comb begin
		// start cycle works on the fresh denominator
		cur_rem  = m.div_start ? '0 : rem_reg;
		cur_den  = m.div_start ? m.div_den : den_reg;
		// dividend has its only one at bit 20
		cur_bit  = m.div_start;
		trial    = {cur_rem, cur_bit};
		diff     = trial - {1'b0, cur_den};
		q_bit    = (trial >= {1'b0, cur_den});
		// either branch is below the denominator
		rem_next = q_bit ? diff[`MRD_PTS_W-1:0] : trial[`MRD_PTS_W-1:0];
	end

	// --------------------------------------------------
	// bit counter and done strobe
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			done_reg <= 1'b0;
		end else begin
			// last step runs while count is 1
			done_reg <= (bit_cnt == 5'd1);
			if (m.div_start) begin
				bit_cnt <= 5'(NUM_BITS - 1);
			end else if (bit_cnt != '0) begin
				bit_cnt <= bit_cnt - 1'b1;
			end
		end
	end

	// partial remainder and quotient shift
	always_ff @(posedge clk) begin
		if (m.div_start) begin
			den_reg  <= m.div_den;
			rem_reg  <= rem_next;
			quot_reg <= {{(`MRD_RECIP_W-1){1'b0}}, q_bit};
		end else if (bit_cnt != '0) begin
			rem_reg  <= rem_next;
			// msb falls off after 20 more shifts
			quot_reg <= {quot_reg[`MRD_RECIP_W-2:0], q_bit};
		end
	end

	assign m.div_done = done_reg;
	assign m.div_quot = quot_reg;
	assign m.div_rem  = rem_reg;

endmodule

/* mrd_ctrl_fsm.sv */
`include "mrd_defines.svh"

module mrd_ctrl_fsm (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    sink_sop,
	input  logic [`MRD_PTS_W-1:0]   dftpts,
	mrd_param_if.ctrl               m,
	output logic                    busy,
	output logic                    params_valid,
	output logic                    param_err,
	output logic [`MRD_RDX_W-1:0]   num_factors,
	output logic [`MRD_RDX_W-1:0]   stage_of_rdx2,
	output mrd_pkg::radix_e         nf        [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_PTS_W-1:0]   twdl_den  [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_PTS_W-1:0]   n_div_nf  [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_RECIP_W-1:0] quotient  [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_PTS_W-1:0]   remainder [0:`MRD_NUM_STAGES-1]
);
	import mrd_pkg::*;

	// stage index meaning "no radix-2 stage"
	localparam logic [`MRD_RDX_W-1:0] NO_RDX2   = 3'd7;
	localparam logic [`MRD_RDX_W-1:0] LAST_SLOT = `MRD_RDX_W'(`MRD_NUM_STAGES);

	ctrl_state_e           state;
	logic [`MRD_RDX_W-1:0] step_cnt;
	logic [`MRD_RDX_W-1:0] rec_idx;
	logic                  div_wait;
	logic                  err_flag;
	logic                  accept;
	logic                  stepping;
	logic                  recip_end;

	// --------------------------------------------------
	// strobes
	// --------------------------------------------------
	// sop only taken when idle
	assign accept    = (state == ST_IDLE) && sink_sop;
	assign stepping  = (state == ST_FACTOR) && (step_cnt != LAST_SLOT);
	// used stages are contiguous from slot 0
	assign recip_end = (state == ST_RECIP) && !div_wait && (rec_idx == num_factors);

	assign m.fact_load = accept;
	assign m.fact_n    = dftpts;
	assign m.fact_step = stepping;
	assign m.div_start = (state == ST_RECIP) && !div_wait && (rec_idx != num_factors);
	assign m.div_den   = (rec_idx < LAST_SLOT) ? twdl_den[rec_idx] : '0;

	assign busy         = (state == ST_FACTOR) || (state == ST_RECIP);
	assign params_valid = (state == ST_DONE);

	// --------------------------------------------------
	// FSM, counters and summary flags
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= ST_IDLE;
			step_cnt      <= '0;
			rec_idx       <= '0;
			div_wait      <= 1'b0;
			err_flag      <= 1'b0;
			param_err     <= 1'b0;
			num_factors   <= '0;
			stage_of_rdx2 <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state         <= ST_FACTOR;
						step_cnt      <= '0;
						rec_idx       <= '0;
						div_wait      <= 1'b0;
						param_err     <= 1'b0;
						num_factors   <= '0;
						stage_of_rdx2 <= NO_RDX2;
					end
				end
				ST_FACTOR: begin
					if (stepping) begin
						step_cnt <= step_cnt + 1'b1;
						if (m.fact_radix != RDX_1) begin
							num_factors <= num_factors + 1'b1;
						end
						// keep the first radix-2 stage only
						if (m.fact_radix == RDX_2 && stage_of_rdx2 == NO_RDX2) begin
							stage_of_rdx2 <= step_cnt;
						end
					end else begin
						// six steps done, residue must be 1 now
						err_flag <= (m.fact_residue != `MRD_PTS_W'(1));
						state    <= ST_RECIP;
					end
				end
				ST_RECIP: begin
					if (m.div_start) begin
						div_wait <= 1'b1;
					end else if (div_wait && m.div_done) begin
						div_wait <= 1'b0;
						rec_idx  <= rec_idx + 1'b1;
					end
					if (recip_end) begin
						param_err <= err_flag;
						state     <= ST_DONE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// parameter tables
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `MRD_NUM_STAGES; i++) begin
				nf[i]        <= radix_e'(3'd0);
				twdl_den[i]  <= '0;
				n_div_nf[i]  <= '0;
				quotient[i]  <= '0;
				remainder[i] <= '0;
			end
		end else begin
			// unused stages end with zero reciprocals
			if (accept) begin
				for (int i = 0; i < `MRD_NUM_STAGES; i++) begin
					quotient[i]  <= '0;
					remainder[i] <= '0;
				end
			end
			// denominator is the residue before the step
			if (stepping) begin
				nf[step_cnt]       <= m.fact_radix;
				twdl_den[step_cnt] <= m.fact_residue;
				n_div_nf[step_cnt] <= m.fact_n_div;
			end
			if (div_wait && m.div_done) begin
				quotient[rec_idx]  <= m.div_quot;
				remainder[rec_idx] <= m.div_rem;
			end
		end
	end

endmodule

/* mrd_param_top.sv */
`include "mrd_defines.svh"

module mrd_param_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    sink_sop,
	input  logic [`MRD_PTS_W-1:0]   dftpts,
	output logic                    busy,
	output logic                    params_valid,
	output logic                    param_err,
	output logic [`MRD_RDX_W-1:0]   num_factors,
	output logic [`MRD_RDX_W-1:0]   stage_of_rdx2,
	output mrd_pkg::radix_e         nf        [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_PTS_W-1:0]   twdl_den  [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_PTS_W-1:0]   n_div_nf  [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_RECIP_W-1:0] quotient  [0:`MRD_NUM_STAGES-1],
	output logic [`MRD_PTS_W-1:0]   remainder [0:`MRD_NUM_STAGES-1]
);

	// control to datapath strobes
	mrd_param_if u_if ();

	// --------------------------------------------------
	// control and parameter tables
	// --------------------------------------------------
	mrd_ctrl_fsm u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.sink_sop      (sink_sop),
		.dftpts        (dftpts),
		.m             (u_if.ctrl),
		.busy          (busy),
		.params_valid  (params_valid),
		.param_err     (param_err),
		.num_factors   (num_factors),
		.stage_of_rdx2 (stage_of_rdx2),
		.nf            (nf),
		.twdl_den      (twdl_den),
		.n_div_nf      (n_div_nf),
		.quotient      (quotient),
		.remainder     (remainder)
	);

	// radix search and residue
	mrd_factorizer u_fact (
		.clk   (clk),
		.rst_n (rst_n),
		.m     (u_if.fact)
	);

	// 2^20 over the stage denominator
	mrd_recip_div u_div (
		.clk   (clk),
		.rst_n (rst_n),
		.m     (u_if.recip)
	);

endmodule

/* mrd_param_properties.sv */
`include "mrd_defines.svh"

module mrd_param_properties (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  busy,
	input logic                  params_valid,
	input logic [`MRD_PTS_W-1:0] twdl_den  [0:`MRD_NUM_STAGES-1],
	input logic [`MRD_PTS_W-1:0] remainder [0:`MRD_NUM_STAGES-1]
);

	// --------------------------------------------------
	// strobes
	// --------------------------------------------------
	// single-cycle valid pulse
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		params_valid |=> !params_valid)
		else $error("params_valid held for more than one cycle");

	// busy ends only as the results come out
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> params_valid)
		else $error("busy fell without params_valid");

	// --------------------------------------------------
	// reciprocal tables
	// --------------------------------------------------
	for (genvar i = 0; i < `MRD_NUM_STAGES; i++) begin : g_rem
		a_rem_below_den: assert property (@(posedge clk) disable iff (!rst_n)
			params_valid |-> (remainder[i] < twdl_den[i]))
			else $error("remainder of stage %0d not below its denominator", i);
	end

endmodule

bind mrd_param_top mrd_param_properties u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.busy         (busy),
	.params_valid (params_valid),
	.twdl_den     (twdl_den),
	.remainder    (remainder)
);

/* tb_mrd_param.sv */
`include "mrd_defines.svh"

module tb_mrd_param;
	import mrd_pkg::*;

	localparam int S          = `MRD_NUM_STAGES;
	localparam int NUM_CASES  = 12;
	localparam int CASE_WORDS = 10;
	localparam int NUM_RAND   = 5;
	localparam int TIMEOUT    = 400;
	localparam int SCALE      = 1 << `MRD_RECIP_W;
	localparam int MAX_N      = (1 << `MRD_PTS_W) - 1;

	logic                    clk;
	logic                    rst_n;
	logic                    sink_sop;
	logic [`MRD_PTS_W-1:0]   dftpts;
	logic                    busy;
	logic                    params_valid;
	logic                    param_err;
	logic [`MRD_RDX_W-1:0]   num_factors;
	logic [`MRD_RDX_W-1:0]   stage_of_rdx2;
	radix_e                  nf        [0:S-1];
	logic [`MRD_PTS_W-1:0]   twdl_den  [0:S-1];
	logic [`MRD_PTS_W-1:0]   n_div_nf  [0:S-1];
	logic [`MRD_RECIP_W-1:0] quotient  [0:S-1];
	logic [`MRD_PTS_W-1:0]   remainder [0:S-1];

	// ten raw words per frame from the cases file
	logic [15:0] case_mem [0:NUM_CASES*CASE_WORDS-1];
	// expected radices and summary of the frame under test
	int          exp_rdx [0:S-1];
	int          exp_nf;
	int          exp_rdx2;
	int          exp_err;
	int          errors;
	int          tests;
	int          failed;
	bit          test_fail;
	logic [31:0] lcg_state;

	mrd_param_top dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.sink_sop      (sink_sop),
		.dftpts        (dftpts),
		.busy          (busy),
		.params_valid  (params_valid),
		.param_err     (param_err),
		.num_factors   (num_factors),
		.stage_of_rdx2 (stage_of_rdx2),
		.nf            (nf),
		.twdl_den      (twdl_den),
		.n_div_nf      (n_div_nf),
		.quotient      (quotient),
		.remainder     (remainder)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input int expv);
		assert (got == expv) else begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expv);
			errors++;
			test_fail = 1'b1;
		end
	endtask

	task automatic finish_test(input string label);
		tests++;
		if (test_fail) begin
			failed++;
			$display("test %s: FAIL", label);
		end else begin
			$display("test %s: PASS", label);
		end
	endtask

	task automatic load_case(input int c, output int n);
		int base;
		base = c * CASE_WORDS;
		n        = int'(case_mem[base]);
		exp_nf   = int'(case_mem[base + 1]);
		for (int i = 0; i < S; i++) begin
			exp_rdx[i] = int'(case_mem[base + 2 + i]);
		end
		exp_rdx2 = int'(case_mem[base + 8]);
		exp_err  = int'(case_mem[base + 9]);
	endtask

	// radix priority is 4 then 2 then 5 then 3
	// no divisor leaves the stage unused
	task automatic factor_ref(input int n);
		int res;
		int r;
		res      = n;
		exp_nf   = 0;
		exp_rdx2 = 7;
		for (int i = 0; i < S; i++) begin
			if (res % 4 == 0) r = 4;
			else if (res % 2 == 0) r = 2;
			else if (res % 5 == 0) r = 5;
			else if (res % 3 == 0) r = 3;
			else r = 1;
			exp_rdx[i] = r;
			if (r != 1) exp_nf++;
			if (r == 2 && exp_rdx2 == 7) exp_rdx2 = i;
			res = res / r;
		end
		exp_err = (res != 1) ? 1 : 0;
	endtask

	// product of up to six factors from 2, 3 and 5
	task automatic make_rand_n(output int n);
		int pick;
		int f;
		n = 1;
		for (int k = 0; k < S; k++) begin
			lcg_state = lcg_next(lcg_state);
			pick = int'((lcg_state >> 16) % 32'd3);
			case (pick)
				0:       f = 2;
				1:       f = 3;
				default: f = 5;
			endcase
			if (n * f <= MAX_N) n = n * f;
		end
	endtask

	// --------------------------------------------------
	// frame driving and checking
	// --------------------------------------------------
	task automatic start_frame(input int n);
		@(posedge clk);
		sink_sop <= 1'b1;
		dftpts   <= `MRD_PTS_W'(n);
		@(posedge clk);
		sink_sop <= 1'b0;
	endtask

	// poll params_valid on the falling edge
	task automatic wait_valid(output bit ok);
		int cnt;
		ok  = 1'b0;
		cnt = 0;
		while (!ok && cnt < TIMEOUT) begin
			@(negedge clk);
			ok = params_valid;
			cnt++;
		end
	endtask

	task automatic check_frame(input int n);
		int den;
		int q;
		int rm;
		den = n;
		// busy drops as the results come out
		check_val("busy", 32'(busy), 0);
		check_val("num_factors", 32'(num_factors), exp_nf);
		check_val("stage_of_rdx2", 32'(stage_of_rdx2), exp_rdx2);
		check_val("param_err", 32'(param_err), exp_err);
		for (int i = 0; i < S; i++) begin
			// floor of 2^20 over the stage denominator
			// unused stages expect zero reciprocals
			q  = (i < exp_nf) ? SCALE / den : 0;
			rm = (i < exp_nf) ? SCALE % den : 0;
			check_val($sformatf("nf[%0d]", i), 32'(nf[i]), exp_rdx[i]);
			check_val($sformatf("twdl_den[%0d]", i), 32'(twdl_den[i]), den);
			check_val($sformatf("n_div_nf[%0d]", i), 32'(n_div_nf[i]), n / exp_rdx[i]);
			check_val($sformatf("quotient[%0d]", i), 32'(quotient[i]), q);
			check_val($sformatf("remainder[%0d]", i), 32'(remainder[i]), rm);
			if (i < exp_nf) begin
				assert (32'(quotient[i]) * den + 32'(remainder[i]) == SCALE) else begin
					$display("stage %0d reciprocal does not rebuild 2^20", i);
					errors++;
					test_fail = 1'b1;
				end
			end
			den = den / exp_rdx[i];
		end
	endtask

	task automatic collect_frame(input int n);
		bit ok;
		wait_valid(ok);
		if (!ok) begin
			$display("timeout waiting for params_valid, N=%0d", n);
			errors++;
			test_fail = 1'b1;
		end else begin
			check_frame(n);
		end
	endtask

	task automatic run_frame(input int n, input string label);
		test_fail = 1'b0;
		start_frame(n);
		collect_frame(n);
		finish_test(label);
	endtask

	task automatic check_reset();
		test_fail = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_val("busy", 32'(busy), 0);
			check_val("params_valid", 32'(params_valid), 0);
			check_val("param_err", 32'(param_err), 0);
		end
		check_val("num_factors", 32'(num_factors), 0);
		check_val("stage_of_rdx2", 32'(stage_of_rdx2), 0);
		for (int i = 0; i < S; i++) begin
			check_val($sformatf("nf[%0d]", i), 32'(nf[i]), 0);
			check_val($sformatf("twdl_den[%0d]", i), 32'(twdl_den[i]), 0);
			check_val($sformatf("n_div_nf[%0d]", i), 32'(n_div_nf[i]), 0);
			check_val($sformatf("quotient[%0d]", i), 32'(quotient[i]), 0);
			check_val($sformatf("remainder[%0d]", i), 32'(remainder[i]), 0);
		end
		finish_test("reset state");
	endtask

	// second sop with another N lands while busy
	// results must still match the first N
	task automatic sop_while_busy();
		int n;
		int cnt;
		bit ok;
		test_fail = 1'b0;
		load_case(0, n);
		start_frame(n);
		cnt = 0;
		ok  = 1'b0;
		while (!ok && cnt < TIMEOUT) begin
			@(negedge clk);
			ok = busy;
			cnt++;
		end
		if (!ok) begin
			$display("busy never went high after sink_sop");
			errors++;
			test_fail = 1'b1;
		end
		start_frame(1152);
		collect_frame(n);
		finish_test("sop ignored while busy");
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		int n;
		errors    = 0;
		tests     = 0;
		failed    = 0;
		test_fail = 1'b0;
		lcg_state = 32'ha6a6bce9;
		rst_n     = 1'b0;
		sink_sop  = 1'b0;
		dftpts    = '0;
		$readmemh("mrd_param_cases.txt", case_mem);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		check_reset();
		// back to back frames from the file
		for (int c = 0; c < NUM_CASES; c++) begin
			load_case(c, n);
			run_frame(n, $sformatf("case %0d N=%0d", c, n));
		end
		sop_while_busy();
		// random products of 2, 3 and 5
		for (int k = 0; k < NUM_RAND; k++) begin
			make_rand_n(n);
			factor_ref(n);
			run_frame(n, $sformatf("random %0d N=%0d", k, n));
		end
		$display("tests %0d, failed %0d, failed checks %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
mrd_pkg.sv
mrd_param_if.sv
mrd_factorizer.sv
mrd_recip_div.sv
mrd_ctrl_fsm.sv
mrd_param_top.sv
mrd_param_properties.sv
tb_mrd_param.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_mrd_param
FILELIST  := vlog.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* mrd_param_cases.txt */
// columns: N, factors, radix of stages 0..5, radix-2 stage, error flag
// all values in hex, one frame per line
4B0 5 4 4 5 5 3 1 7 0
480 6 4 4 4 2 3 3 3 0
578 4 4 2 5 5 1 1 1 1
040 3 4 4 4 1 1 1 7 0
002 1 2 1 1 1 1 1 0 0
001 0 1 1 1 1 1 1 7 0
88B 6 3 3 3 3 3 3 7 1
FA0 6 4 4 2 5 5 5 2 0
C35 5 5 5 5 5 5 1 7 0
3C0 5 4 4 4 5 3 1 7 0
FFF 3 5 3 3 1 1 1 7 1
006 2 2 3 1 1 1 1 0 0
